// File: Makefile
VERILATOR ?= verilator
TOP ?= batchReconTb
FILELIST ?= batchRecon.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard rtl/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// File: batchRecon.f
+incdir+rtl
rtl/batchReconPkg.sv
rtl/sampleBufIf.sv
rtl/coefRegs.sv
rtl/batchSequencer.sv
rtl/sampleBuffer.sv
rtl/lookaheadRecursion.sv
rtl/lookbackRecursion.sv
rtl/resultCombiner.sv
rtl/batchRecon.sv
tests/batchReconTb.sv

// File: rtl/batchRecon.sv
`timescale 1ns/1ps

module batchRecon (
    input  logic                clkRecurse,
    input  logic                rst,
    input  logic                in,
    input  logic                cfgWrite,
    input  logic                cfgAddr,
    input  batchReconPkg::coefT cfgData,
    output batchReconPkg::outT  out,
    output logic                outValid
);

    batchReconPkg::coefT pole;
    batchReconPkg::coefT gain;
    batchReconPkg::accT fwdState;
    batchReconPkg::accT bwdState;
    batchReconPkg::resIdxT resIdx;
    batchReconPkg::bankT bankPhase;
    logic batchStart;
    logic lhEn;
    logic calcEn;
    logic decim;
    logic started;

    sampleBufIf sampleBus ();

    coefRegs u_coefRegs (
        .clkRecurse (clkRecurse),
        .rst        (rst),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgData    (cfgData),
        .batchStart (batchStart),
        .pole       (pole),
        .gain       (gain)
    );

    batchSequencer u_batchSequencer (
        .clkRecurse (clkRecurse),
        .rst        (rst),
        .in         (in),
        .bufIf      (sampleBus),
        .batchStart (batchStart),
        .lhEn       (lhEn),
        .calcEn     (calcEn),
        .decim      (decim),
        .resIdx     (resIdx),
        .bankPhase  (bankPhase),
        .started    (started)
    );

    sampleBuffer u_sampleBuffer (
        .clkRecurse (clkRecurse),
        .bufIf      (sampleBus)
    );

    lookaheadRecursion u_lookaheadRecursion (
        .clkRecurse (clkRecurse),
        .rst        (rst),
        .data       (sampleBus),
        .pole       (pole),
        .gain       (gain),
        .lhEn       (lhEn),
        .calcEn     (calcEn),
        .batchStart (batchStart),
        .bwdState   (bwdState)
    );

    lookbackRecursion u_lookbackRecursion (
        .clkRecurse (clkRecurse),
        .rst        (rst),
        .data       (sampleBus),
        .pole       (pole),
        .gain       (gain),
        .calcEn     (calcEn),
        .fwdState   (fwdState)
    );

    resultCombiner u_resultCombiner (
        .clkRecurse (clkRecurse),
        .rst        (rst),
        .fwdState   (fwdState),
        .bwdState   (bwdState),
        .decim      (decim),
        .resIdx     (resIdx),
        .bankPhase  (bankPhase),
        .started    (started),
        .out        (out),
        .outValid   (outValid)
    );

endmodule

// File: rtl/batchReconPkg.sv
`include "batchRecon_cfg.svh"

package batchReconPkg;

    typedef logic [$clog2(`BR_BATCH)-1:0] sampleIdxT;
    typedef logic [1:0] bankT;
    // Bank number on top, sample index below
    typedef logic [$clog2(`BR_BATCH)+1:0] bufAddrT;
    typedef logic [`BR_COEF_W-1:0] coefT;
    typedef logic signed [`BR_ACC_W-1:0] accT;
    typedef logic [$clog2(`BR_BATCH/`BR_DSR)-1:0] resIdxT;
    typedef logic [`BR_OUT_W-1:0] outT;

    // One recursion step, pole*prev >>> 15 plus gain*x with x = +1 or -1
    function automatic accT recStep(accT prev, coefT pole, coefT gain, logic x);
        logic signed [`BR_ACC_W+`BR_COEF_W:0] prod;
        accT gainExt;
        prod = prev * $signed({1'b0, pole});
        prod = prod >>> (`BR_COEF_W - 1);
        gainExt = accT'($signed(gain));
        return accT'(prod) + (x ? gainExt : -gainExt);
    endfunction

endpackage

// File: rtl/batchRecon_cfg.svh
`ifndef BATCH_RECON_CFG_SVH
`define BATCH_RECON_CFG_SVH

// Batch geometry
`define BR_BATCH 16
// Must divide BR_BATCH
`define BR_DSR 4

// Datapath widths
`define BR_COEF_W 16
`define BR_ACC_W 24
`define BR_OUT_W 12

// Right shift from the combined sum to the output field
`define BR_SHIFT 6

// Coefficient values after reset
// Pole is unsigned Q0.15, gain is signed
`define BR_POLE_RST 16'h7C00
`define BR_GAIN_RST 16'h0100

`endif

// File: rtl/batchSequencer.sv
`timescale 1ns/1ps
`include "batchRecon_cfg.svh"

module batchSequencer (
    input  logic                   clkRecurse,
    input  logic                   rst,
    input  logic                   in,
    sampleBufIf.sequencer          bufIf,
    output logic                   batchStart,
    output logic                   lhEn,
    output logic                   calcEn,
    output logic                   decim,
    output batchReconPkg::resIdxT  resIdx,
    output batchReconPkg::bankT    bankPhase,
    output logic                   started
);

    localparam int LAST = `BR_BATCH - 1;

    batchReconPkg::sampleIdxT idx;
    batchReconPkg::sampleIdxT idxRev;
    batchReconPkg::bankT bank;
    batchReconPkg::bankT bankLh;
    batchReconPkg::bankT bankCalc;
    logic [1:0] fillCnt;
    logic full;
    logic periodEnd;
    logic decimD1;
    batchReconPkg::resIdxT resIdxD1;
    batchReconPkg::bankT bankD1;

    assign periodEnd = (idx == batchReconPkg::sampleIdxT'(LAST));
    assign idxRev = batchReconPkg::sampleIdxT'(LAST) - idx;

    // Lookahead reads p-1, calculation reads p-3
    assign bankLh = bank - 2'd1;
    assign bankCalc = bank + 2'd1;

    assign bufIf.wrEn = 1'b1;
    assign bufIf.wrData = in;
    assign bufIf.wrAddr = {bank, idx};
    assign bufIf.rdAddrLh = {bankLh, idxRev};
    assign bufIf.rdAddrFwd = {bankCalc, idx};
    assign bufIf.rdAddrBwd = {bankCalc, idxRev};

    // Sample index, bank rotation and fill tracking
    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            idx <= '0;
            bank <= '0;
            fillCnt <= '0;
            full <= 1'b0;
        end else begin
            if (periodEnd) begin
                idx <= '0;
                bank <= bank + 2'd1;
                if (!full) begin
                    if (fillCnt == 2'd2) begin
                        full <= 1'b1;
                    end else begin
                        fillCnt <= fillCnt + 2'd1;
                    end
                end
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Stage 1 lines up with read data, stage 2 with the recursion state
    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            batchStart <= 1'b0;
            lhEn <= 1'b0;
            calcEn <= 1'b0;
            started <= 1'b0;
            decimD1 <= 1'b0;
            decim <= 1'b0;
            resIdxD1 <= '0;
            resIdx <= '0;
            bankD1 <= '0;
            bankPhase <= '0;
        end else begin
            batchStart <= (idx == '0);
            lhEn <= 1'b1;
            calcEn <= full;
            started <= calcEn;
            decimD1 <= ((idx % `BR_DSR) == `BR_DSR - 1);
            decim <= decimD1;
            resIdxD1 <= batchReconPkg::resIdxT'(idx / `BR_DSR);
            resIdx <= resIdxD1;
            bankD1 <= bank;
            bankPhase <= bankD1;
        end
    end

endmodule

// File: rtl/coefRegs.sv
`timescale 1ns/1ps
`include "batchRecon_cfg.svh"

module coefRegs (
    input  logic                clkRecurse,
    input  logic                rst,
    input  logic                cfgWrite,
    input  logic                cfgAddr,
    input  batchReconPkg::coefT cfgData,
    input  logic                batchStart,
    output batchReconPkg::coefT pole,
    output batchReconPkg::coefT gain
);

    batchReconPkg::coefT poleShadow;
    batchReconPkg::coefT gainShadow;

    // Shadow copies, written at any time
    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            poleShadow <= `BR_POLE_RST;
            gainShadow <= `BR_GAIN_RST;
        end else if (cfgWrite) begin
            if (cfgAddr) begin
                gainShadow <= cfgData;
            end else begin
                poleShadow <= cfgData;
            end
        end
    end

    // Active set only moves at a batch boundary
    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            pole <= `BR_POLE_RST;
            gain <= `BR_GAIN_RST;
        end else if (batchStart) begin
            pole <= poleShadow;
            gain <= gainShadow;
        end
    end

endmodule

// File: rtl/lookaheadRecursion.sv
`timescale 1ns/1ps
`include "batchRecon_cfg.svh"

module lookaheadRecursion (
    input  logic                clkRecurse,
    input  logic                rst,
    sampleBufIf.consumer        data,
    input  batchReconPkg::coefT pole,
    input  batchReconPkg::coefT gain,
    input  logic                lhEn,
    input  logic                calcEn,
    input  logic                batchStart,
    output batchReconPkg::accT  bwdState
);

    // Shifts backward points onto the forward decimation slots
    localparam int BWD_DLY = `BR_DSR - 1;

    batchReconPkg::accT lhState;
    batchReconPkg::accT bwdMain;
    batchReconPkg::accT lhPrev;
    batchReconPkg::accT bwdPrev;
    batchReconPkg::accT bwdPipe [BWD_DLY];

    // Warm-up restarts from zero, main pass picks up the warm-up result
    assign lhPrev = batchStart ? '0 : lhState;
    assign bwdPrev = batchStart ? lhState : bwdMain;

    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            lhState <= '0;
            bwdMain <= '0;
        end else begin
            if (lhEn) begin
                lhState <= batchReconPkg::recStep(lhPrev, pole, gain, data.rdDataLh);
            end
            if (calcEn) begin
                bwdMain <= batchReconPkg::recStep(bwdPrev, pole, gain, data.rdDataBwd);
            end
        end
    end

    // Alignment delay toward the combiner
    always_ff @(posedge clkRecurse) begin
        bwdPipe[0] <= bwdMain;
        for (int i = 1; i < BWD_DLY; i++) begin
            bwdPipe[i] <= bwdPipe[i-1];
        end
    end

    assign bwdState = bwdPipe[BWD_DLY-1];

endmodule

// File: rtl/lookbackRecursion.sv
`timescale 1ns/1ps

module lookbackRecursion (
    input  logic                clkRecurse,
    input  logic                rst,
    sampleBufIf.consumer        data,
    input  batchReconPkg::coefT pole,
    input  batchReconPkg::coefT gain,
    input  logic                calcEn,
    output batchReconPkg::accT  fwdState
);

    batchReconPkg::accT fwdNext;

    // Next state from the forward-ordered sample
    assign fwdNext = batchReconPkg::recStep(fwdState, pole, gain, data.rdDataFwd);

    // State runs on across batches and never restarts
    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            fwdState <= '0;
        end else if (calcEn) begin
            fwdState <= fwdNext;
        end
    end

endmodule

// File: rtl/resultCombiner.sv
`timescale 1ns/1ps
`include "batchRecon_cfg.svh"

module resultCombiner (
    input  logic                  clkRecurse,
    input  logic                  rst,
    input  batchReconPkg::accT    fwdState,
    input  batchReconPkg::accT    bwdState,
    input  logic                  decim,
    input  batchReconPkg::resIdxT resIdx,
    input  batchReconPkg::bankT   bankPhase,
    input  logic                  started,
    output batchReconPkg::outT    out,
    output logic                  outValid
);

    localparam int NRES = `BR_BATCH / `BR_DSR;
    localparam int TOP = `BR_SHIFT + `BR_OUT_W - 1;

    // Ping-pong halves selected by the delayed bank phase
    batchReconPkg::accT fwdMem [2][NRES];
    batchReconPkg::accT bwdMem [2][NRES];

    logic wrHalf;
    logic rdHalf;
    logic wrEn;
    logic rdEn;
    logic filled;
    logic rdValid;
    batchReconPkg::resIdxT bwdIdx;
    batchReconPkg::accT fwdRd;
    batchReconPkg::accT bwdRd;
    logic signed [`BR_ACC_W:0] sum;

    assign wrHalf = bankPhase[0];
    assign rdHalf = ~bankPhase[0];
    assign wrEn = decim & started;
    assign rdEn = decim & filled;

    // Backward results arrive last sample first
    assign bwdIdx = batchReconPkg::resIdxT'(NRES - 1) - resIdx;

    always_ff @(posedge clkRecurse) begin
        if (wrEn) begin
            fwdMem[wrHalf][resIdx] <= fwdState;
            bwdMem[wrHalf][bwdIdx] <= bwdState;
        end
        fwdRd <= fwdMem[rdHalf][resIdx];
        bwdRd <= bwdMem[rdHalf][resIdx];
    end

    assign sum = fwdRd + bwdRd;

    // Readout starts once one whole batch sits in the other half
    always_ff @(posedge clkRecurse or negedge rst) begin
        if (!rst) begin
            filled <= 1'b0;
            rdValid <= 1'b0;
            outValid <= 1'b0;
            out <= '0;
        end else begin
            if (wrEn && resIdx == batchReconPkg::resIdxT'(NRES - 1)) begin
                filled <= 1'b1;
            end
            rdValid <= rdEn;
            outValid <= rdValid;
            if (rdValid) begin
                // Offset binary
                out <= {~sum[TOP], sum[TOP-1:`BR_SHIFT]};
            end
        end
    end

endmodule

// File: rtl/sampleBufIf.sv
`timescale 1ns/1ps

interface sampleBufIf;

    // Write side, one sample per cycle
    logic wrEn;
    batchReconPkg::bufAddrT wrAddr;
    logic wrData;

    // Lookahead, forward and backward read addresses
    batchReconPkg::bufAddrT rdAddrLh;
    batchReconPkg::bufAddrT rdAddrFwd;
    batchReconPkg::bufAddrT rdAddrBwd;

    // Registered read data
    logic rdDataLh;
    logic rdDataFwd;
    logic rdDataBwd;

    modport sequencer (
        output wrEn, wrAddr, wrData,
        output rdAddrLh, rdAddrFwd, rdAddrBwd
    );

    modport buffer (
        input  wrEn, wrAddr, wrData,
        input  rdAddrLh, rdAddrFwd, rdAddrBwd,
        output rdDataLh, rdDataFwd, rdDataBwd
    );

    modport consumer (
        input rdDataLh, rdDataFwd, rdDataBwd
    );

endinterface

// File: rtl/sampleBuffer.sv
`timescale 1ns/1ps
`include "batchRecon_cfg.svh"

module sampleBuffer (
    input logic        clkRecurse,
    sampleBufIf.buffer bufIf
);

    localparam int DEPTH = 4 * `BR_BATCH;

    // Four banks of one-bit samples
    logic mem [DEPTH];

    always_ff @(posedge clkRecurse) begin
        if (bufIf.wrEn) begin
            mem[bufIf.wrAddr] <= bufIf.wrData;
        end
    end

    // Registered reads, data one cycle after address
    always_ff @(posedge clkRecurse) begin
        bufIf.rdDataLh <= mem[bufIf.rdAddrLh];
        bufIf.rdDataFwd <= mem[bufIf.rdAddrFwd];
        bufIf.rdDataBwd <= mem[bufIf.rdAddrBwd];
    end

endmodule

// File: tests/batchReconTb.sv
`timescale 1ns/1ps
`include "batchRecon_cfg.svh"

module batchReconTb;

    localparam int NRES = `BR_BATCH / `BR_DSR;

    logic clkRecurse = 1'b0;
    logic rst;
    logic in;
    logic cfgWrite;
    logic cfgAddr;
    batchReconPkg::coefT cfgData;
    batchReconPkg::outT out;
    logic outValid;

    // Every bit driven since the last reset release
    bit sampleBits[$];
    logic [31:0] rngState = 32'd86;
    logic [15:0] modelPole;
    logic [15:0] modelGain;
    batchReconPkg::outT expOut;
    string testName;
    int errorCount = 0;
    int totalChecked = 0;
    int batchNum;
    int resultNum;
    int checked;
    bit timedOut = 1'b0;

    batchRecon u_batchRecon (
        .clkRecurse (clkRecurse),
        .rst        (rst),
        .in         (in),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgData    (cfgData),
        .out        (out),
        .outValid   (outValid)
    );

    always #4 clkRecurse = ~clkRecurse;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // One recursion step, wrapped to the state width
    function automatic longint stepModel(longint prev, bit x);
        longint next;
        logic [`BR_ACC_W-1:0] wrapped;
        next = (prev * longint'(modelPole)) >>> (`BR_COEF_W - 1);
        next = x ? next + longint'($signed(modelGain)) : next - longint'($signed(modelGain));
        wrapped = next[`BR_ACC_W-1:0];
        return longint'($signed(wrapped));
    endfunction

    // Expected output for result m of batch k
    function automatic batchReconPkg::outT refOut(int k, int m);
        longint fwd;
        longint bwd;
        logic [63:0] sum;
        batchReconPkg::outT field;
        int n;
        n = k * `BR_BATCH + m * `BR_DSR + `BR_DSR - 1;
        fwd = 0;
        bwd = 0;
        for (int i = 0; i <= n; i++) begin
            fwd = stepModel(fwd, sampleBits[i]);
        end
        // Warm-up over batch k+1 runs straight on into batch k
        for (int i = (k + 2) * `BR_BATCH - 1; i >= n; i--) begin
            bwd = stepModel(bwd, sampleBits[i]);
        end
        sum = fwd + bwd;
        field = sum[`BR_SHIFT +: `BR_OUT_W];
        field[`BR_OUT_W-1] = ~field[`BR_OUT_W-1];
        return field;
    endfunction

    // Results arrive in batch order, ascending within a batch
    always @(negedge clkRecurse) begin
        if (!rst) begin
            batchNum = 0;
            resultNum = 0;
            checked = 0;
        end else if (outValid) begin
            expOut = refOut(batchNum, resultNum);
            assert (out === expOut) else begin
                errorCount++;
                $display("MISMATCH %s batch %0d result %0d expected %03h actual %03h",
                         testName, batchNum, resultNum, expOut, out);
            end
            resultNum++;
            if (resultNum == NRES) begin
                resultNum = 0;
                batchNum++;
            end
            checked++;
            totalChecked++;
        end
    end

    task automatic driveBit(input bit randomBits);
        bit b;
        @(negedge clkRecurse);
        rngState = xorshift(rngState);
        b = randomBits ? rngState[0] : 1'b1;
        in = b;
        sampleBits.push_back(b);
    endtask

    task automatic holdReset();
        @(negedge clkRecurse);
        rst = 1'b0;
        in = 1'b0;
        cfgWrite = 1'b0;
        repeat (15) begin
            @(negedge clkRecurse);
            assert (!outValid && out == '0) else begin
                errorCount++;
                $display("Outputs not quiet while reset is held");
            end
        end
    endtask

    // Releases reset and streams bits until all results of nBatches are checked
    task automatic runTest(input bit randomBits, input int nBatches, input bit writeCfg);
        int cycle;
        int limit;
        limit = (nBatches + 8) * `BR_BATCH;
        sampleBits.delete();
        cycle = 0;
        while (checked < nBatches * NRES && cycle < limit) begin
            driveBit(randomBits);
            rst = 1'b1;
            // New coefficients reach the shadow registers early in batch 0
            cfgWrite = writeCfg && (cycle == 3 || cycle == 4);
            cfgAddr = (cycle == 4);
            cfgData = (cycle == 4) ? modelGain : modelPole;
            if (cycle < 3 * `BR_BATCH) begin
                assert (!outValid && out == '0) else begin
                    errorCount++;
                    $display("Output active before the first batch result in %s", testName);
                end
            end
            cycle++;
        end
        if (checked < nBatches * NRES) begin
            errorCount++;
            timedOut = 1'b1;
            $display("Timed out waiting for the results of %s", testName);
        end
    endtask

    task automatic countPulses(input int nPeriods);
        int pulses;
        pulses = 0;
        repeat (nPeriods * `BR_BATCH) begin
            driveBit(1'b1);
            if (outValid) begin
                pulses++;
            end
        end
        assert (pulses == nPeriods * NRES) else begin
            errorCount++;
            $display("MISMATCH %s expected %0d actual %0d", testName, nPeriods * NRES, pulses);
        end
    endtask

    initial begin
        rst = 1'b0;
        in = 1'b0;
        cfgWrite = 1'b0;
        cfgAddr = 1'b0;
        cfgData = '0;
        modelPole = `BR_POLE_RST;
        modelGain = `BR_GAIN_RST;
        holdReset();
        testName = "allOnes";
        runTest(1'b0, 12, 1'b0);
        if (!timedOut) begin
            holdReset();
            testName = "randomStream";
            runTest(1'b1, 20, 1'b0);
        end
        if (!timedOut) begin
            testName = "pulseCount";
            countPulses(8);
        end
        if (!timedOut) begin
            holdReset();
            testName = "newCoefs";
            modelPole = 16'h7800;
            modelGain = 16'hFE80;
            runTest(1'b1, 16, 1'b1);
        end
        $display("Checked %0d results, %0d errors", totalChecked, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
